// ==== source/cpu_pkg.sv ====
package cpu_pkg;

    typedef logic [15:0] word_t;
    typedef logic [15:0] instr_t;
    typedef logic [3:0]  reg_addr_t;
    typedef logic [2:0]  flags_t;      // {equal, less, greater}

    // Bit positions inside flags_t
    localparam int flag_eq = 2;
    localparam int flag_lt = 1;
    localparam int flag_gt = 0;

    // Instruction bits 15:13
    typedef enum logic [2:0] {
        op_load_dir  = 3'b000,
        op_jump      = 3'b001,
        op_store_dir = 3'b010,
        op_load_imm  = 3'b011,
        op_branch    = 3'b100,
        op_add_imm   = 3'b101,
        op_sub_imm   = 3'b110,
        op_reg       = 3'b111
    } major_op_t;

    // Register op function in bits 11:8 when bit 12 is clear
    typedef enum logic [3:0] {
        alu_add = 4'd0,
        alu_sub = 4'd1,
        alu_mul = 4'd2,
        alu_and = 4'd3,
        alu_or  = 4'd4,
        alu_xor = 4'd5,
        alu_not = 4'd6,
        alu_neg = 4'd7,
        alu_cmp = 4'd8
    } alu_op_t;

    typedef enum logic [1:0] {
        br_eq = 2'b00,
        br_ne = 2'b01,
        br_lt = 2'b10,
        br_gt = 2'b11
    } branch_cond_t;

endpackage

// ==== source/fetch_unit.sv ====
`timescale 1ns/1ps

module fetch_unit
    import cpu_pkg::*;
#(
    parameter int ADDR_WIDTH = 16
)
(
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  mem_rdy,
    input  logic                  mem_cplt,
    input  word_t                 mem_data_out,
    output logic [ADDR_WIDTH-1:0] mem_addr,
    output logic                  mem_r_en,
    input  logic                  take,
    input  logic                  fetch_hold,
    input  logic                  redirect,
    input  logic [ADDR_WIDTH-1:0] redirect_addr,
    output logic                  instr_valid,
    output instr_t                instr,
    output logic [ADDR_WIDTH-1:0] instr_addr
);

    logic [ADDR_WIDTH-1:0] pc;
    logic                  waiting;     // Request accepted and word not back yet
    logic                  running;
    logic                  accept;
    logic                  capture;

    assign mem_addr = pc;
    assign mem_r_en = running && !waiting && (!instr_valid || take) && !fetch_hold;
    assign accept   = mem_r_en && mem_rdy;
    assign capture  = mem_cplt && waiting;

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            pc          <= '0;
            waiting     <= 1'b0;
            running     <= 1'b0;
            instr_valid <= 1'b0;
        end
        else
        begin
            running <= 1'b1;
            if (redirect)
                pc <= redirect_addr;
            else if (accept)
                pc <= pc + 1'b1;

            if (accept)
                waiting <= 1'b1;
            else if (mem_cplt)
                waiting <= 1'b0;

            if (capture)
                instr_valid <= 1'b1;
            else if (take)
                instr_valid <= 1'b0;
        end
    end

    // PC already stepped past the returned word
    always_ff @(posedge clk)
    begin
        if (capture)
        begin
            instr      <= mem_data_out;
            instr_addr <= pc - 1'b1;
        end
    end

endmodule

// ==== source/instr_decode.sv ====
`timescale 1ns/1ps

module instr_decode
    import cpu_pkg::*;
#(
    parameter int ADDR_WIDTH = 16
)
(
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  instr_valid,
    input  instr_t                instr,
    input  logic [ADDR_WIDTH-1:0] instr_addr,
    output logic                  take,
    output logic                  fetch_hold,
    output reg_addr_t             reg_r_addr_1,
    output reg_addr_t             reg_r_addr_2,
    input  word_t                 reg_r_data_1,
    input  word_t                 reg_r_data_2,
    input  logic                  wb_valid,
    input  logic                  wb_wr,
    input  reg_addr_t             wb_dest,
    input  logic                  wb_control,
    output logic                  ex_valid,
    output word_t                 ex_op_a,
    output word_t                 ex_op_b,
    output alu_op_t               ex_alu_op,
    output reg_addr_t             ex_dest,
    output logic                  ex_wr,
    output logic                  ex_jump,
    output logic                  ex_branch,
    output branch_cond_t          ex_cond,
    output logic [ADDR_WIDTH-1:0] ex_addr,
    output logic [ADDR_WIDTH-1:0] ex_offset
);

    major_op_t             op;
    word_t                 dec_op_a;
    word_t                 dec_op_b;
    alu_op_t               dec_alu_op;
    logic                  dec_wr;
    logic                  dec_jump;
    logic                  dec_branch;
    logic [ADDR_WIDTH-1:0] dec_offset;
    logic                  needs_1;     // Reads reg[7:4]
    logic                  needs_2;     // Reads reg[3:0]
    logic                  busy_1;
    logic                  busy_2;

    assign op           = major_op_t'(instr[15:13]);
    assign reg_r_addr_1 = instr[7:4];
    assign reg_r_addr_2 = instr[3:0];

    always_comb
    begin
        dec_op_a   = reg_r_data_2;
        dec_op_b   = reg_r_data_1;
        dec_alu_op = alu_add;
        dec_wr     = 1'b0;
        dec_jump   = 1'b0;
        dec_branch = 1'b0;
        needs_1    = 1'b0;
        needs_2    = 1'b0;
        dec_offset = {{(ADDR_WIDTH-11){instr[10]}}, instr[10:0]};
        case (op)
            op_jump:
            begin
                dec_jump   = 1'b1;
                dec_offset = {{(ADDR_WIDTH-13){instr[12]}}, instr[12:0]};
            end
            op_branch:
                dec_branch = 1'b1;
            op_load_imm:
            begin
                needs_2  = 1'b1;
                dec_wr   = 1'b1;
                dec_op_b = '0;
                if (instr[12])
                    dec_op_a = {instr[11:4], reg_r_data_2[7:0]};   // Upper byte
                else
                    dec_op_a = {reg_r_data_2[15:8], instr[11:4]};
            end
            op_add_imm, op_sub_imm:
            begin
                needs_2    = 1'b1;
                dec_wr     = 1'b1;
                dec_op_b   = {7'b0, instr[12:4]};
                dec_alu_op = (op == op_sub_imm) ? alu_sub : alu_add;
            end
            op_reg:
            begin
                if (!instr[12] && instr[11:8] <= alu_cmp)
                begin
                    dec_alu_op = alu_op_t'(instr[11:8]);
                    needs_2    = 1'b1;
                    needs_1    = (dec_alu_op != alu_not) && (dec_alu_op != alu_neg);
                    dec_wr     = (dec_alu_op != alu_cmp);
                end
                else if (instr[12] && instr[11:8] == 4'd2)
                begin
                    // Move passes through the adder
                    needs_1  = 1'b1;
                    dec_wr   = 1'b1;
                    dec_op_a = reg_r_data_1;
                    dec_op_b = '0;
                end
            end
            default: ;  // Memory ops retire as no-ops
        endcase
    end

    // Without forwarding a reader waits for the producer's write
    assign busy_1 = (ex_valid && ex_wr && ex_dest == reg_r_addr_1) ||
                    (wb_valid && wb_wr && wb_dest == reg_r_addr_1);
    assign busy_2 = (ex_valid && ex_wr && ex_dest == reg_r_addr_2) ||
                    (wb_valid && wb_wr && wb_dest == reg_r_addr_2);

    assign take = instr_valid && !((needs_1 && busy_1) || (needs_2 && busy_2));

    assign fetch_hold = (instr_valid && (dec_jump || dec_branch)) ||
                        (ex_valid && (ex_jump || ex_branch)) ||
                        (wb_valid && wb_control);

    // Stage 1 reloads every cycle since stage 2 never stalls
    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            ex_valid  <= 1'b0;
            ex_wr     <= 1'b0;
            ex_jump   <= 1'b0;
            ex_branch <= 1'b0;
        end
        else
        begin
            ex_valid <= take;
            if (take)
            begin
                ex_wr     <= dec_wr;
                ex_jump   <= dec_jump;
                ex_branch <= dec_branch;
            end
        end
    end

    always_ff @(posedge clk)
    begin
        if (take)
        begin
            ex_op_a   <= dec_op_a;
            ex_op_b   <= dec_op_b;
            ex_alu_op <= dec_alu_op;
            ex_dest   <= instr[3:0];
            ex_cond   <= branch_cond_t'(instr[12:11]);
            ex_addr   <= instr_addr;
            ex_offset <= dec_offset;
        end
    end

endmodule

// ==== source/alu.sv ====
`timescale 1ns/1ps

module alu
    import cpu_pkg::*;
(
    input  logic    clk,
    input  logic    rst,
    input  logic    ex_valid,
    input  word_t   ex_op_a,
    input  word_t   ex_op_b,
    input  alu_op_t ex_alu_op,
    output word_t   ex_result,
    output flags_t  flags
);

    always_comb
    begin
        case (ex_alu_op)
            alu_add: ex_result = ex_op_a + ex_op_b;
            alu_sub: ex_result = ex_op_a - ex_op_b;
            alu_mul: ex_result = ex_op_a * ex_op_b;     // Low half only
            alu_and: ex_result = ex_op_a & ex_op_b;
            alu_or:  ex_result = ex_op_a | ex_op_b;
            alu_xor: ex_result = ex_op_a ^ ex_op_b;
            alu_not: ex_result = ~ex_op_a;
            alu_neg: ex_result = -ex_op_a;
            default: ex_result = '0;
        endcase
    end

    // Unsigned compare flags held until the next compare
    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            flags <= '0;
        end
        else if (ex_valid && ex_alu_op == alu_cmp)
        begin
            flags[flag_eq] <= (ex_op_a == ex_op_b);
            flags[flag_lt] <= (ex_op_a < ex_op_b);
            flags[flag_gt] <= (ex_op_a > ex_op_b);
        end
    end

endmodule

// ==== source/branch_unit.sv ====
`timescale 1ns/1ps

module branch_unit
    import cpu_pkg::*;
#(
    parameter int ADDR_WIDTH = 16
)
(
    input  logic                  ex_jump,
    input  logic                  ex_branch,
    input  branch_cond_t          ex_cond,
    input  flags_t                flags,
    input  logic [ADDR_WIDTH-1:0] ex_addr,
    input  logic [ADDR_WIDTH-1:0] ex_offset,
    output logic                  ex_taken,
    output logic [ADDR_WIDTH-1:0] ex_target
);

    logic cond_ok;

    always_comb
    begin
        case (ex_cond)
            br_eq:   cond_ok = flags[flag_eq];
            br_ne:   cond_ok = !flags[flag_eq];
            br_lt:   cond_ok = flags[flag_lt];
            default: cond_ok = flags[flag_gt];
        endcase
    end

    assign ex_taken  = ex_jump || (ex_branch && cond_ok);
    assign ex_target = ex_addr + ex_offset;    // Offset arrives sign-extended

endmodule

// ==== source/writeback_stage.sv ====
`timescale 1ns/1ps

module writeback_stage
    import cpu_pkg::*;
#(
    parameter int ADDR_WIDTH = 16
)
(
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  ex_valid,
    input  logic                  ex_wr,
    input  logic                  ex_control,
    input  logic                  ex_taken,
    input  word_t                 ex_result,
    input  reg_addr_t             ex_dest,
    input  logic [ADDR_WIDTH-1:0] ex_target,
    output logic                  reg_w_en,
    output reg_addr_t             reg_w_addr,
    output word_t                 reg_w_data,
    output logic                  wb_valid,
    output logic                  wb_wr,
    output logic                  wb_control,
    output reg_addr_t             wb_dest,
    output logic                  redirect,
    output logic [ADDR_WIDTH-1:0] redirect_addr
);

    logic                  wb_taken;
    word_t                 wb_data;
    logic [ADDR_WIDTH-1:0] wb_target;

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            wb_valid   <= 1'b0;
            wb_wr      <= 1'b0;
            wb_control <= 1'b0;
            wb_taken   <= 1'b0;
        end
        else
        begin
            wb_valid   <= ex_valid;     // Drains every cycle
            wb_wr      <= ex_wr;
            wb_control <= ex_control;
            wb_taken   <= ex_taken;
        end
    end

    always_ff @(posedge clk)
    begin
        wb_data   <= ex_result;
        wb_dest   <= ex_dest;
        wb_target <= ex_target;
    end

    assign reg_w_en   = wb_valid && wb_wr;
    assign reg_w_addr = wb_dest;
    assign reg_w_data = wb_data;

    // Not-taken branch just releases the fetch hold
    assign redirect      = wb_valid && wb_taken;
    assign redirect_addr = wb_target;

endmodule

// ==== source/cpu_core.sv ====
`timescale 1ns/1ps

module cpu_core
    import cpu_pkg::*;
#(
    parameter int ADDR_WIDTH = 16     // At least 13 for the jump offset
)
(
    input  logic                  clk,
    input  logic                  rst,
    output logic [ADDR_WIDTH-1:0] mem_addr,
    output logic                  mem_r_en,
    input  word_t                 mem_data_out,
    input  logic                  mem_rdy,
    input  logic                  mem_cplt,
    output reg_addr_t             reg_r_addr_1,
    output reg_addr_t             reg_r_addr_2,
    input  word_t                 reg_r_data_1,
    input  word_t                 reg_r_data_2,
    output logic                  reg_w_en,
    output reg_addr_t             reg_w_addr,
    output word_t                 reg_w_data
);

    logic                  take;
    logic                  fetch_hold;
    logic                  redirect;
    logic [ADDR_WIDTH-1:0] redirect_addr;
    logic                  instr_valid;
    instr_t                instr;
    logic [ADDR_WIDTH-1:0] instr_addr;
    logic                  ex_valid;
    word_t                 ex_op_a;
    word_t                 ex_op_b;
    alu_op_t               ex_alu_op;
    reg_addr_t             ex_dest;
    logic                  ex_wr;
    logic                  ex_jump;
    logic                  ex_branch;
    branch_cond_t          ex_cond;
    logic [ADDR_WIDTH-1:0] ex_addr;
    logic [ADDR_WIDTH-1:0] ex_offset;
    word_t                 ex_result;
    flags_t                flags;
    logic                  ex_taken;
    logic [ADDR_WIDTH-1:0] ex_target;
    logic                  wb_valid;
    logic                  wb_wr;
    logic                  wb_control;
    reg_addr_t             wb_dest;

    fetch_unit #(.ADDR_WIDTH(ADDR_WIDTH)) u_fetch (
        .clk(clk), .rst(rst),
        .mem_rdy(mem_rdy), .mem_cplt(mem_cplt), .mem_data_out(mem_data_out),
        .mem_addr(mem_addr), .mem_r_en(mem_r_en),
        .take(take), .fetch_hold(fetch_hold),
        .redirect(redirect), .redirect_addr(redirect_addr),
        .instr_valid(instr_valid), .instr(instr), .instr_addr(instr_addr)
    );

    instr_decode #(.ADDR_WIDTH(ADDR_WIDTH)) u_decode (
        .clk(clk), .rst(rst),
        .instr_valid(instr_valid), .instr(instr), .instr_addr(instr_addr),
        .take(take), .fetch_hold(fetch_hold),
        .reg_r_addr_1(reg_r_addr_1), .reg_r_addr_2(reg_r_addr_2),
        .reg_r_data_1(reg_r_data_1), .reg_r_data_2(reg_r_data_2),
        .wb_valid(wb_valid), .wb_wr(wb_wr), .wb_dest(wb_dest), .wb_control(wb_control),
        .ex_valid(ex_valid), .ex_op_a(ex_op_a), .ex_op_b(ex_op_b),
        .ex_alu_op(ex_alu_op), .ex_dest(ex_dest), .ex_wr(ex_wr),
        .ex_jump(ex_jump), .ex_branch(ex_branch), .ex_cond(ex_cond),
        .ex_addr(ex_addr), .ex_offset(ex_offset)
    );

    alu u_alu (
        .clk(clk), .rst(rst), .ex_valid(ex_valid),
        .ex_op_a(ex_op_a), .ex_op_b(ex_op_b), .ex_alu_op(ex_alu_op),
        .ex_result(ex_result), .flags(flags)
    );

    branch_unit #(.ADDR_WIDTH(ADDR_WIDTH)) u_branch (
        .ex_jump(ex_jump), .ex_branch(ex_branch), .ex_cond(ex_cond), .flags(flags),
        .ex_addr(ex_addr), .ex_offset(ex_offset),
        .ex_taken(ex_taken), .ex_target(ex_target)
    );

    writeback_stage #(.ADDR_WIDTH(ADDR_WIDTH)) u_writeback (
        .clk(clk), .rst(rst),
        .ex_valid(ex_valid), .ex_wr(ex_wr), .ex_control(ex_jump | ex_branch),
        .ex_taken(ex_taken), .ex_result(ex_result), .ex_dest(ex_dest),
        .ex_target(ex_target),
        .reg_w_en(reg_w_en), .reg_w_addr(reg_w_addr), .reg_w_data(reg_w_data),
        .wb_valid(wb_valid), .wb_wr(wb_wr), .wb_control(wb_control), .wb_dest(wb_dest),
        .redirect(redirect), .redirect_addr(redirect_addr)
    );

endmodule

// ==== dv/tb_clock.sv ====
`timescale 1ns/1ps

module tb_clock
(
    output logic clk,
    output logic rst
);

    initial
    begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    initial
    begin
        rst = 1'b1;
        repeat (8) @(posedge clk);
        rst <= 1'b0;
    end

endmodule

// ==== dv/cpu_properties.sv ====
`timescale 1ns/1ps

module cpu_properties
#(
    parameter int ADDR_WIDTH = 16
)
(
    input logic                  clk,
    input logic                  rst,
    input logic [ADDR_WIDTH-1:0] mem_addr,
    input logic                  mem_r_en,
    input logic                  mem_rdy,
    input logic                  mem_cplt,
    input logic                  reg_w_en
);

    logic pending;     // Accepted fetch not completed yet

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
            pending <= 1'b0;
        else if (mem_r_en && mem_rdy)
            pending <= 1'b1;
        else if (mem_cplt)
            pending <= 1'b0;
    end

    // Refused request must hold until accepted
    assert property (@(posedge clk) disable iff (rst)
        (mem_r_en && !mem_rdy) |=> (mem_r_en && $stable(mem_addr)))
        else $error("fetch request changed while waiting for mem_rdy");

    assert property (@(posedge clk) rst |-> (!reg_w_en && !mem_r_en))
        else $error("write or fetch enable high during reset");

    // One fetch outstanding at most
    assert property (@(posedge clk) disable iff (rst)
        pending |-> !mem_r_en)
        else $error("fetch request issued while another is outstanding");

endmodule

bind cpu_core cpu_properties #(.ADDR_WIDTH(ADDR_WIDTH)) u_props (
    .clk(clk), .rst(rst), .mem_addr(mem_addr), .mem_r_en(mem_r_en), .mem_rdy(mem_rdy),
    .mem_cplt(mem_cplt), .reg_w_en(reg_w_en)
);

// ==== dv/tb_top.sv ====
`timescale 1ns/1ps

module tb_top
    import cpu_pkg::*;
;

    logic        clk;
    logic        rst;
    logic [15:0] mem_addr;
    logic        mem_r_en;
    word_t       mem_data_out = '0;
    logic        mem_rdy = 1'b0;
    logic        mem_cplt = 1'b0;
    reg_addr_t   reg_r_addr_1;
    reg_addr_t   reg_r_addr_2;
    word_t       reg_r_data_1;
    word_t       reg_r_data_2;
    logic        reg_w_en;
    reg_addr_t   reg_w_addr;
    word_t       reg_w_data;

    instr_t      imem [0:255];
    word_t       rf [0:15];
    word_t       model [0:15];
    reg_addr_t   exp_addr [$];
    word_t       exp_data [$];
    logic [31:0] seed = 32'hb115_eca8;
    int          prog_len;
    int          halt_addr;
    int          errors;
    int          timeouts;

    // Memory side state
    logic        busy;
    int          delay;
    logic [7:0]  lat_addr;

    tb_clock u_clock (.clk(clk), .rst(rst));

    cpu_core #(.ADDR_WIDTH(16)) u_dut (
        .clk(clk), .rst(rst),
        .mem_addr(mem_addr), .mem_r_en(mem_r_en), .mem_data_out(mem_data_out),
        .mem_rdy(mem_rdy), .mem_cplt(mem_cplt),
        .reg_r_addr_1(reg_r_addr_1), .reg_r_addr_2(reg_r_addr_2),
        .reg_r_data_1(reg_r_data_1), .reg_r_data_2(reg_r_data_2),
        .reg_w_en(reg_w_en), .reg_w_addr(reg_w_addr), .reg_w_data(reg_w_data)
    );

    function logic [31:0] next_rand();
        seed = seed * 32'd1664525 + 32'd1013904223;
        return seed;
    endfunction

    function void emit(instr_t w);
        imem[prog_len] = w;
        prog_len++;
    endfunction

    function void emit_li(reg_addr_t rd, word_t v);
        emit({3'b011, 1'b0, v[7:0], rd});
        emit({3'b011, 1'b1, v[15:8], rd});
    endfunction

    function void build_program();
        word_t pairs [0:5];
        for (int i = 0; i < 256; i++)
            imem[i] = {3'b000, 13'(i * 7 + 3)};  // Memory ops that retire as no-ops
        prog_len = 0;
        emit_li(1, 16'h12ab);
        emit_li(2, 16'hf00d);
        emit({3'b101, 9'd300, 4'd1});
        emit({3'b110, 9'd77, 4'd2});
        emit({3'b111, 1'b1, 4'd2, 4'd1, 4'd3});  // Move r3 = r1
        emit({3'b010, 13'h0005});
        for (int fn = 0; fn <= 8; fn++)
            for (int rep = 0; rep < 2; rep++)
            begin
                emit_li(4, 16'(next_rand() >> 8));
                emit_li(5, 16'(next_rand() >> 8));
                emit({3'b111, 1'b0, 4'(fn), 4'd4, 4'd5});
            end
        // Dependent chain
        emit({3'b101, 9'd1, 4'd6});
        emit({3'b101, 9'd2, 4'd6});
        emit({3'b111, 1'b0, 4'd0, 4'd6, 4'd7});
        emit({3'b111, 1'b0, 4'd2, 4'd6, 4'd7});
        pairs = '{16'd5, 16'd5, 16'd3, 16'd7, 16'd7, 16'd3};
        for (int p = 0; p < 3; p++)
        begin
            emit_li(8, pairs[2*p]);
            emit_li(9, pairs[2*p+1]);
            emit({3'b111, 1'b0, 4'd8, 4'd9, 4'd8});
            for (int c = 0; c < 4; c++)
            begin
                emit({3'b100, 2'(c), 11'd2});
                emit({3'b101, 9'(p * 4 + c + 1), 4'd10});   // Skipped when taken
            end
        end
        emit({3'b001, 13'd3});
        emit({3'b101, 9'd5, 4'd11});
        emit({3'b101, 9'd6, 4'd11});
        emit({3'b101, 9'd9, 4'd12});
        halt_addr = prog_len;
        emit({3'b001, 13'd0});
    endfunction

    function void model_write(reg_addr_t rd, word_t v);
        model[rd] = v;
        exp_addr.push_back(rd);
        exp_data.push_back(v);
    endfunction

    // ISA model runs until the self jump
    function void ref_run();
        int     pc;
        int     next;
        logic   halted;
        logic   taken;
        logic   f_eq;
        logic   f_lt;
        logic   f_gt;
        instr_t w;
        word_t  a;
        word_t  b;
        pc = 0;
        halted = 1'b0;
        {f_eq, f_lt, f_gt} = 3'b000;
        for (int i = 0; i < 16; i++)
            model[i] = 16'(i * 16'h1111);
        for (int steps = 0; steps < 2000 && !halted; steps++)
        begin
            w = imem[pc];
            a = model[w[3:0]];
            b = model[w[7:4]];
            next = pc + 1;
            case (w[15:13])
                3'b001:
                begin
                    halted = (w[12:0] == 13'd0);
                    next = pc + int'($signed(w[12:0]));
                end
                3'b100:
                begin
                    case (w[12:11])
                        2'b00: taken = f_eq;
                        2'b01: taken = !f_eq;
                        2'b10: taken = f_lt;
                        default: taken = f_gt;
                    endcase
                    if (taken)
                        next = pc + int'($signed(w[10:0]));
                end
                3'b011: model_write(w[3:0], w[12] ? {w[11:4], a[7:0]} : {a[15:8], w[11:4]});
                3'b101: model_write(w[3:0], a + {7'b0, w[12:4]});
                3'b110: model_write(w[3:0], a - {7'b0, w[12:4]});
                3'b111:
                begin
                    if (!w[12])
                        case (w[11:8])
                            4'd0: model_write(w[3:0], a + b);
                            4'd1: model_write(w[3:0], a - b);
                            4'd2: model_write(w[3:0], a * b);
                            4'd3: model_write(w[3:0], a & b);
                            4'd4: model_write(w[3:0], a | b);
                            4'd5: model_write(w[3:0], a ^ b);
                            4'd6: model_write(w[3:0], ~a);
                            4'd7: model_write(w[3:0], -a);
                            4'd8: {f_eq, f_lt, f_gt} = {a == b, a < b, a > b};
                            default: ;
                        endcase
                    else if (w[11:8] == 4'd2)
                        model_write(w[3:0], b);
                end
                default: ;
            endcase
            pc = next;
        end
    endfunction

    assign reg_r_data_1 = rf[reg_r_addr_1];
    assign reg_r_data_2 = rf[reg_r_addr_2];

    always @(posedge clk)
    begin
        if (rst)
        begin
            for (int r = 0; r < 16; r++)
                rf[r] <= 16'(r * 16'h1111);
        end
        else if (reg_w_en)
            rf[reg_w_addr] <= reg_w_data;
    end

    // Instruction memory with random ready and 1 to 3 cycle completion
    always @(posedge clk)
    begin
        mem_cplt <= 1'b0;
        mem_rdy  <= 1'(next_rand() >> 31);
        if (rst)
        begin
            busy <= 1'b0;
        end
        else if (busy)
        begin
            if (delay == 1)
            begin
                mem_cplt     <= 1'b1;
                mem_data_out <= imem[lat_addr];
                busy         <= 1'b0;
            end
            delay <= delay - 1;
        end
        else if (mem_r_en && mem_rdy)
        begin
            busy     <= 1'b1;
            lat_addr <= mem_addr[7:0];
            delay    <= 1 + int'((next_rand() >> 16) % 3);
        end
    end

    always @(posedge clk)
    begin
        if (!rst && reg_w_en)
        begin
            if (exp_addr.size() == 0)
            begin
                $display("Unexpected register write to r%0d at %0t", reg_w_addr, $time);
                errors++;
            end
            else
            begin
                if (reg_w_addr != exp_addr[0])
                begin
                    $display("ERROR %0t reg_w_addr exp %h got %h", $time, exp_addr[0], reg_w_addr);
                    errors++;
                end
                if (reg_w_data != exp_data[0])
                begin
                    $display("ERROR %0t reg_w_data exp %h got %h", $time, exp_data[0], reg_w_data);
                    errors++;
                end
                void'(exp_addr.pop_front());
                void'(exp_data.pop_front());
            end
        end
    end

    initial
    begin
        int i;
        errors   = 0;
        timeouts = 0;
        build_program();
        ref_run();
        for (i = 0; i < 100 && rst !== 1'b0; i++)
            @(negedge clk);
        if (rst !== 1'b0)
        begin
            $display("Timed out waiting for reset release");
            timeouts++;
        end
        for (i = 0; i < 20000 && exp_addr.size() != 0; i++)
            @(negedge clk);
        if (exp_addr.size() != 0)
        begin
            $display("Timed out with %0d register writes missing", exp_addr.size());
            timeouts++;
        end
        for (i = 0; i < 2000 && mem_addr != 16'(halt_addr); i++)
            @(negedge clk);
        if (mem_addr != 16'(halt_addr))
        begin
            $display("Timed out waiting for fetch of the halt address");
            timeouts++;
        end
        repeat (30) @(negedge clk);   // Let any stray write show up
        for (i = 0; i < 16; i++)
            if (rf[i] != model[i])
            begin
                $display("ERROR %0t rf[%0d] exp %h got %h", $time, i, model[i], rf[i]);
                errors++;
            end
        $display("Checks done, errors %0d, timeouts %0d", errors, timeouts);
        if (errors == 0 && timeouts == 0)
            $display("** PASS **");
        else
            $display("** FAIL **");
        $finish;
    end

endmodule

// ==== tb.f ====
source/cpu_pkg.sv
source/fetch_unit.sv
source/instr_decode.sv
source/alu.sv
source/branch_unit.sv
source/writeback_stage.sv
source/cpu_core.sv
dv/tb_clock.sv
dv/cpu_properties.sv
dv/tb_top.sv

// ==== run.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -Wno-fatal --top-module tb_top -f tb.f -o sim_tb
./obj_dir/sim_tb | tee sim.log
if grep -q '\*\* PASS \*\*' sim.log; then
    exit 0
else
    exit 1
fi
